// File: sim.f
source/usbProtoPkg.sv
source/sieCfgPkg.sv
source/usbCrc.sv
source/usbBitStuffer.sv
source/usbTx.sv
source/usbRx.sv
source/usbSie.sv
tb/usbSieTb.sv

// File: source/sieCfgPkg.sv
`default_nettype none

package sieCfgPkg;

    // One byte of the caller interface, PID or payload
    typedef logic [7:0] byteT;

    // Payload limit of a full-speed bulk endpoint
    localparam int DefaultMaxPacketBytes = 64;

    // Receive controller states
    typedef enum logic [1:0] {
        RxHunt, // Line idle, waiting for the first K
        RxSync, // Shifting in bits until the sync byte matches
        RxData, // Unstuffing and byte assembly
        RxDone  // EOP seen, last byte handed out with its verdict
    } rxStateT;

endpackage

`default_nettype wire

// File: source/usbBitStuffer.sv
`timescale 1ns/100ps
`default_nettype none

// Ones counter for bit stuffing, serves whichever path owns the line
module usbBitStuffer (
    input logic clk12_i,
    input logic reset_i,
    input logic stuffClear_i,
    input logic bitValid_i,
    input logic bit_i,
    input logic isSendingPhase_i,
    output logic stuffNow_o,    // Tx inserts a zero, rx drops the next bit
    output logic stuffError_o   // Sticky, seven ones in a row on receive
);
    import usbProtoPkg::*;

    logic [2:0] onesCnt;

    always_ff @(posedge clk12_i) begin
        if (reset_i || stuffClear_i) begin
            onesCnt <= '0;
            stuffError_o <= 1'b0;
        end else if (bitValid_i) begin
            if (bit_i) begin
                // A one where a stuffed zero belongs
                if ((onesCnt == stuffRunLength) && !isSendingPhase_i) begin
                    stuffError_o <= 1'b1;
                end
                if (onesCnt != 3'd7) begin
                    onesCnt <= onesCnt + 3'd1; // Saturate
                end
            end else begin
                onesCnt <= '0;  // Any zero ends the run, stuffed or not
            end
        end
    end

    assign stuffNow_o = (onesCnt >= stuffRunLength);

endmodule

`default_nettype wire

// File: source/usbCrc.sv
`timescale 1ns/100ps
`default_nettype none

// Bit serial CRC16, shared by the transmit and the receive path
module usbCrc (
    input logic clk12_i,
    input logic reset_i,
    input logic crcClear_i,     // Preset the register to all ones
    input logic bitValid_i,     // bit_i is consumed in this cycle
    input logic bit_i,
    output logic [15:0] crc_o,  // Inverted register, sent MSB first by usbTx
    output logic crcOk_o        // Residual matches after data plus CRC
);
    import usbProtoPkg::*;

    logic [15:0] crcReg;
    logic feedback;

    // Data arrives LSB first, so the top bit leaves the register first
    assign feedback = bit_i ^ crcReg[15];

    always_ff @(posedge clk12_i) begin
        if (reset_i || crcClear_i) begin
            crcReg <= '1;
        end else if (bitValid_i) begin
            crcReg <= {crcReg[14:0], 1'b0} ^ (feedback ? crc16Poly : 16'h0000);
        end
    end

    assign crc_o = ~crcReg;
    assign crcOk_o = (crcReg == crc16Residual); // Only meaningful after the last CRC bit

endmodule

`default_nettype wire

// File: source/usbProtoPkg.sv
`default_nettype none

package usbProtoPkg;

    // ========================================
    // Line level protocol constants
    // ========================================

    // Sync byte, shifted out LSB first (KJKJKJKK on the line)
    localparam logic [7:0] syncPattern = 8'h80;

    // A zero is stuffed after this many consecutive ones
    localparam int stuffRunLength = 6;

    // SE0 cycles of the end-of-packet, a single J cycle follows
    localparam int eopSe0Cycles = 2;

    // ========================================
    // CRC16 of data packets
    // ========================================

    localparam logic [15:0] crc16Poly = 16'h8005;      // x^16 + x^15 + x^2 + 1
    localparam logic [15:0] crc16Residual = 16'h800D;  // Register value once data and CRC passed

endpackage

`default_nettype wire

// File: source/usbRx.sv
`timescale 1ns/100ps
`default_nettype none

// Receive path: sync hunt, NRZI decode, unstuffing and CRC holdback
module usbRx #(
    parameter int MaxPacketBytes = sieCfgPkg::DefaultMaxPacketBytes
) (
    input logic clk12_i,
    input logic reset_i,
    input logic lineP_i,
    input logic lineN_i,
    // Caller side
    input logic rxAcceptNewData_i,
    output sieCfgPkg::byteT rxData_o,
    output logic rxDataValid_o,
    output logic rxIsLastByte_o,
    output logic keepPacket_o,
    // Shared engines
    input logic crcOk_i,
    input logic stuffNow_i,
    input logic stuffError_i,
    output logic crcClear_o,
    output logic crcBitValid_o,
    output logic crcBit_o,
    output logic stuffClear_o,
    output logic stuffBitValid_o,
    output logic stuffBit_o
);
    import usbProtoPkg::*;
    import sieCfgPkg::*;

    localparam int CntW = $clog2(MaxPacketBytes + 5); // PID, payload, CRC, saturation

    rxStateT state;
    logic prevLevel, se0, lineK, rxBit, bitTaken, byteDone;
    byteT window, byteSr, newByte;
    byteT holdQ [3];            // holdQ[0] oldest; two CRC bytes plus the last candidate
    logic [1:0] holdCnt;
    logic [2:0] bitCnt;
    logic [CntW-1:0] byteCnt;
    logic pidOk, overrun, verdict, lastPending;

    assign se0 = !lineP_i && !lineN_i;
    assign lineK = !lineP_i && lineN_i;
    assign rxBit = (lineP_i == prevLevel);          // NRZI, no transition is a one
    assign bitTaken = (state == RxData) && !se0 && !stuffNow_i;
    assign byteDone = bitTaken && (bitCnt == 3'd7);
    assign newByte = {rxBit, byteSr[7:1]};          // LSB first

    assign crcClear_o = (state == RxHunt) || (state == RxSync);
    assign stuffClear_o = crcClear_o;
    assign stuffBitValid_o = (state == RxData) && !se0; // Stuffed bits too, for error check
    assign stuffBit_o = rxBit;
    assign crcBitValid_o = bitTaken && (byteCnt != '0); // PID is outside the CRC
    assign crcBit_o = rxBit;

    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            state <= RxHunt;
            prevLevel <= 1'b1;
            rxDataValid_o <= 1'b0;
            rxIsLastByte_o <= 1'b0;
            keepPacket_o <= 1'b0;
            holdCnt <= '0;
            bitCnt <= '0;
            byteCnt <= '0;
            pidOk <= 1'b0;
            overrun <= 1'b0;
            verdict <= 1'b0;
            lastPending <= 1'b0;
        end else begin
            prevLevel <= lineP_i;
            if (rxDataValid_o && rxAcceptNewData_i) begin
                rxDataValid_o <= 1'b0;
                rxIsLastByte_o <= 1'b0;
                keepPacket_o <= 1'b0;
            end
            case (state)
                RxHunt: if (lineK) begin
                    window <= 8'h7F;        // First sync bit already decoded
                    state <= RxSync;
                end
                RxSync: begin
                    window <= {rxBit, window[7:1]};
                    if (se0) begin
                        state <= RxHunt;
                    end else if ({rxBit, window[7:1]} == syncPattern) begin
                        bitCnt <= '0;
                        byteCnt <= '0;
                        holdCnt <= '0;
                        overrun <= 1'b0;
                        state <= RxData;
                    end
                end
                RxData: if (se0) begin
                    // ========================================
                    // Packet verdict at the start of EOP
                    // ========================================
                    verdict <= pidOk && !stuffError_i && crcOk_i && !overrun
                            && (bitCnt == 3'd0) && (byteCnt >= CntW'(3))
                            && (int'(byteCnt) <= MaxPacketBytes + 3);
                    lastPending <= (holdCnt != 2'd0);
                    state <= RxDone;
                end else if (bitTaken) begin
                    byteSr <= newByte;
                    bitCnt <= bitCnt + 3'd1;
                    if (byteDone) begin
                        if (byteCnt != '1) begin
                            byteCnt <= byteCnt + 1'b1;
                        end
                        if (byteCnt == '0) begin
                            pidOk <= (newByte[3:0] == ~newByte[7:4]); // PID check field
                        end
                        if (holdCnt == 2'd3) begin
                            // Oldest byte is now known to be payload
                            if (rxDataValid_o && !rxAcceptNewData_i) begin
                                overrun <= 1'b1;
                            end
                            rxData_o <= holdQ[0];
                            rxDataValid_o <= 1'b1;
                            rxIsLastByte_o <= 1'b0;
                            keepPacket_o <= 1'b0;
                            holdQ[0] <= holdQ[1];
                            holdQ[1] <= holdQ[2];
                            holdQ[2] <= newByte;
                        end else begin
                            holdQ[holdCnt] <= newByte;
                            holdCnt <= holdCnt + 2'd1;
                        end
                    end
                end
                default: if (lastPending) begin
                    // Last byte waits for a free output slot
                    if (!rxDataValid_o || rxAcceptNewData_i) begin
                        rxData_o <= holdQ[0];
                        rxDataValid_o <= 1'b1;
                        rxIsLastByte_o <= 1'b1;
                        keepPacket_o <= verdict;
                        lastPending <= 1'b0;
                    end
                end else if (!se0) begin
                    state <= RxHunt;        // EOP over
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/usbSie.sv
`timescale 1ns/100ps
`default_nettype none

// SIE top: both paths plus the engines they take turns on
module usbSie #(
    parameter int MaxPacketBytes = sieCfgPkg::DefaultMaxPacketBytes
) (
    input logic clk12_i,
    input logic reset_i,
    input logic isSendingPhase_i,       // Selects the owner of CRC and stuffer
    // Transmit caller
    input logic txReqSendPacket_i,
    input logic txDataValid_i,
    input logic txIsLastByte_i,
    input sieCfgPkg::byteT txData_i,
    output logic txAcceptNewData_o,
    output logic txDoneSending_o,
    // Receive caller
    input logic rxAcceptNewData_i,
    output sieCfgPkg::byteT rxData_o,
    output logic rxDataValid_o,
    output logic rxIsLastByte_o,
    output logic keepPacket_o,
    // Line
    input logic lineP_i,
    input logic lineN_i,
    output logic lineP_o,
    output logic lineN_o,
    output logic lineOe_o
);
    logic txCrcClear, txCrcBitValid, txCrcBit, txStuffClear, txStuffBitValid, txStuffBit;
    logic rxCrcClear, rxCrcBitValid, rxCrcBit, rxStuffClear, rxStuffBitValid, rxStuffBit;
    logic crcClear, crcBitValid, crcBit, stuffClear, stuffBitValid, stuffBit;
    logic [15:0] crc;
    logic crcOk, stuffNow, stuffError;

    // ========================================
    // Shared engine input select
    // ========================================
    assign {crcClear, crcBitValid, crcBit, stuffClear, stuffBitValid, stuffBit} =
        isSendingPhase_i ?
            {txCrcClear, txCrcBitValid, txCrcBit, txStuffClear, txStuffBitValid, txStuffBit} :
            {rxCrcClear, rxCrcBitValid, rxCrcBit, rxStuffClear, rxStuffBitValid, rxStuffBit};

    usbCrc crcEngine (
        .clk12_i(clk12_i), .reset_i(reset_i),
        .crcClear_i(crcClear), .bitValid_i(crcBitValid), .bit_i(crcBit),
        .crc_o(crc), .crcOk_o(crcOk)
    );

    usbBitStuffer stuffEngine (
        .clk12_i(clk12_i), .reset_i(reset_i),
        .stuffClear_i(stuffClear), .bitValid_i(stuffBitValid), .bit_i(stuffBit),
        .isSendingPhase_i(isSendingPhase_i),
        .stuffNow_o(stuffNow), .stuffError_o(stuffError)
    );

    usbTx #(.MaxPacketBytes(MaxPacketBytes)) txPath (
        .clk12_i(clk12_i), .reset_i(reset_i),
        .txReqSendPacket_i(txReqSendPacket_i), .txDataValid_i(txDataValid_i),
        .txIsLastByte_i(txIsLastByte_i), .txData_i(txData_i),
        .txAcceptNewData_o(txAcceptNewData_o), .txDoneSending_o(txDoneSending_o),
        .crc_i(crc), .stuffNow_i(stuffNow),
        .crcClear_o(txCrcClear), .crcBitValid_o(txCrcBitValid), .crcBit_o(txCrcBit),
        .stuffClear_o(txStuffClear), .stuffBitValid_o(txStuffBitValid),
        .stuffBit_o(txStuffBit),
        .lineP_o(lineP_o), .lineN_o(lineN_o), .lineOe_o(lineOe_o)
    );

    usbRx #(.MaxPacketBytes(MaxPacketBytes)) rxPath (
        .clk12_i(clk12_i), .reset_i(reset_i),
        .lineP_i(lineP_i), .lineN_i(lineN_i),
        .rxAcceptNewData_i(rxAcceptNewData_i), .rxData_o(rxData_o),
        .rxDataValid_o(rxDataValid_o), .rxIsLastByte_o(rxIsLastByte_o),
        .keepPacket_o(keepPacket_o),
        .crcOk_i(crcOk), .stuffNow_i(stuffNow), .stuffError_i(stuffError),
        .crcClear_o(rxCrcClear), .crcBitValid_o(rxCrcBitValid), .crcBit_o(rxCrcBit),
        .stuffClear_o(rxStuffClear), .stuffBitValid_o(rxStuffBitValid),
        .stuffBit_o(rxStuffBit)
    );

endmodule

`default_nettype wire

// File: source/usbTx.sv
`timescale 1ns/100ps
`default_nettype none

// Transmit path: sync, bytes, CRC16, stuffing, NRZI and EOP
module usbTx #(
    parameter int MaxPacketBytes = sieCfgPkg::DefaultMaxPacketBytes
) (
    input logic clk12_i,
    input logic reset_i,
    // Caller side
    input logic txReqSendPacket_i,
    input logic txDataValid_i,
    input logic txIsLastByte_i,
    input sieCfgPkg::byteT txData_i,
    output logic txAcceptNewData_o,
    output logic txDoneSending_o,
    // Shared engines
    input logic [15:0] crc_i,
    input logic stuffNow_i,
    output logic crcClear_o,
    output logic crcBitValid_o,
    output logic crcBit_o,
    output logic stuffClear_o,
    output logic stuffBitValid_o,
    output logic stuffBit_o,
    // Line
    output logic lineP_o,
    output logic lineN_o,
    output logic lineOe_o
);
    import usbProtoPkg::*;
    import sieCfgPkg::*;

    localparam int TxCntW = $clog2(MaxPacketBytes + 2); // PID plus payload

    typedef enum logic [2:0] {TxIdle, TxSync, TxData, TxCrc, TxUnder, TxEop, TxDone} txStateT;

    txStateT state;
    logic [4:0] bitCnt;         // Bit within sync, byte or CRC; bit 4 marks CRC done
    logic [2:0] eopCnt;
    logic [TxCntW-1:0] txByteCnt;
    byteT holdData;             // One byte holding register
    logic holdFull, holdLast, lastTaken;
    byteT shiftData;            // Byte on the wire
    logic shiftLast, shiftIsPid;
    logic crcDone, stuffing, dataBit, txBit, byteDue;
    logic driveSe0, nrziOn, nextP;

    // ========================================
    // Bit selection
    // ========================================

    assign crcDone = bitCnt[4];
    assign stuffing = stuffNow_i && ((state == TxData) || (state == TxCrc));
    assign dataBit = (state == TxCrc) ? crc_i[~bitCnt[3:0]] : shiftData[bitCnt[2:0]];
    assign byteDue = ((state == TxSync) && (bitCnt == 5'd7))
                  || ((state == TxData) && !stuffing && (bitCnt == 5'd7) && !shiftLast);

    always_comb begin
        case (state)
            TxIdle: txBit = syncPattern[0];             // Leaves on the request cycle
            TxSync: txBit = syncPattern[bitCnt[2:0]];
            TxData, TxCrc: txBit = stuffing ? 1'b0 : dataBit;
            default: txBit = 1'b1;                      // Underrun sends raw ones
        endcase
    end

    always_comb begin
        driveSe0 = 1'b0;
        nrziOn = 1'b0;
        case (state)
            TxIdle: nrziOn = txReqSendPacket_i;
            TxSync, TxData: nrziOn = 1'b1;
            TxCrc: begin
                driveSe0 = crcDone && !stuffing;   // Trailing stuff bit goes first
                nrziOn = !driveSe0;
            end
            TxUnder: begin
                driveSe0 = (bitCnt == 5'd7);
                nrziOn = !driveSe0;
            end
            TxEop: driveSe0 = (eopCnt < eopSe0Cycles);
            default: ;
        endcase
    end

    // NRZI, a zero toggles the line; J when neither data nor SE0
    assign nextP = driveSe0 ? 1'b0 : (nrziOn ? (txBit ? lineP_o : !lineP_o) : 1'b1);

    // Shared engines, sync is neither stuffed nor covered by the CRC
    assign crcClear_o = (state == TxIdle) || (state == TxSync);
    assign stuffClear_o = crcClear_o;
    assign stuffBitValid_o = (state == TxData) || ((state == TxCrc) && !crcDone) || stuffing;
    assign stuffBit_o = txBit;
    assign crcBitValid_o = (state == TxData) && !stuffing && !shiftIsPid;
    assign crcBit_o = shiftData[bitCnt[2:0]];

    assign txAcceptNewData_o = ((state == TxSync) || (state == TxData)) && !holdFull
                            && !lastTaken && (txByteCnt <= TxCntW'(MaxPacketBytes));

    // ========================================
    // Sequencer
    // ========================================

    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            state <= TxIdle;
            bitCnt <= '0;
            eopCnt <= '0;
            txByteCnt <= '0;
            holdFull <= 1'b0;
            lastTaken <= 1'b0;
            shiftLast <= 1'b0;
            shiftIsPid <= 1'b0;
            txDoneSending_o <= 1'b0;
            lineOe_o <= 1'b0;
            lineP_o <= 1'b1;    // J
            lineN_o <= 1'b0;
        end else begin
            lineP_o <= nextP;
            lineN_o <= !driveSe0 && !nextP;
            txDoneSending_o <= 1'b0;
            if (txDataValid_i && txAcceptNewData_o) begin // Handshake
                holdData <= txData_i;
                holdLast <= txIsLastByte_i;
                holdFull <= 1'b1;
                lastTaken <= txIsLastByte_i;
                txByteCnt <= txByteCnt + 1'b1;
            end
            case (state)
                TxIdle: if (txReqSendPacket_i) begin
                    lineOe_o <= 1'b1;
                    bitCnt <= 5'd1;
                    txByteCnt <= '0;
                    holdFull <= 1'b0;
                    lastTaken <= 1'b0;
                    state <= TxSync;
                end
                TxSync: bitCnt <= bitCnt + 5'd1;
                TxData, TxCrc: begin
                    if (state == TxData && !stuffing && bitCnt == 5'd7 && shiftLast) begin
                        bitCnt <= '0;
                        state <= TxCrc;
                    end else if (driveSe0) begin
                        eopCnt <= 3'd1;
                        state <= TxEop;
                    end else if (!stuffing) begin
                        bitCnt <= bitCnt + 5'd1;   // Stuffed zeros hold the position
                    end
                end
                TxUnder: if (driveSe0) begin
                    eopCnt <= 3'd1;
                    state <= TxEop;
                end else begin
                    bitCnt <= bitCnt + 5'd1;
                end
                TxEop: if (eopCnt <= eopSe0Cycles) begin
                    eopCnt <= eopCnt + 3'd1;        // SE0 cycles, then one J
                end else begin
                    lineOe_o <= 1'b0;
                    state <= TxDone;
                end
                default: begin
                    txDoneSending_o <= 1'b1;        // Cycle after lineOe_o fell
                    state <= TxIdle;
                end
            endcase
            if (byteDue) begin
                bitCnt <= '0;
                if (holdFull) begin
                    shiftData <= holdData;
                    shiftLast <= holdLast;
                    shiftIsPid <= (state == TxSync);
                    holdFull <= 1'b0;
                    state <= TxData;
                end else begin
                    state <= TxUnder;   // Caller too late, abort the packet
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/usbSieTb.sv
`timescale 1ns/100ps
`default_nettype none

// Loopback testbench that replays the line of each sent packet into rx
module usbSieTb;
    import usbProtoPkg::*;
    import sieCfgPkg::*;

    localparam int NumRows = 9;
    localparam int MaxLen = DefaultMaxPacketBytes;
    localparam int TimeoutCycles = 2000;
    localparam int FaultNone = 0;
    localparam int FaultFlip = 1;   // Arg is the line sample to invert
    localparam int FaultUnder = 2;  // Arg is the payload byte that never comes
    localparam int FaultStall = 3;  // Arg is how long rx accept stays low

    logic clk12_i;
    logic reset_i;
    logic isSendingPhase_i;
    logic txReqSendPacket_i, txDataValid_i, txIsLastByte_i;
    byteT txData_i;
    logic txAcceptNewData_o, txDoneSending_o;
    logic rxAcceptNewData_i;
    byteT rxData_o;
    logic rxDataValid_o, rxIsLastByte_o, keepPacket_o;
    logic lineP_i, lineN_i;
    logic lineP_o, lineN_o, lineOe_o;
    rxStateT rxStateLabel;          // Receive FSM state by name

    // Stimulus table with one entry per packet
    int rowPid [NumRows];
    int rowLen [NumRows];
    int rowFault [NumRows];
    int rowArg [NumRows];
    int rowKeep [NumRows];          // Expected keepPacket_o on the last byte
    byteT payload [NumRows][MaxLen];
    int rowCount;
    integer seed;

    logic [1:0] lineRec [$];        // {P, N} of every cycle with lineOe_o high
    logic recordLine;

    usbSie #(.MaxPacketBytes(MaxLen)) UUT (
        .clk12_i(clk12_i),
        .reset_i(reset_i),
        .isSendingPhase_i(isSendingPhase_i),
        .txReqSendPacket_i(txReqSendPacket_i),
        .txDataValid_i(txDataValid_i),
        .txIsLastByte_i(txIsLastByte_i),
        .txData_i(txData_i),
        .txAcceptNewData_o(txAcceptNewData_o),
        .txDoneSending_o(txDoneSending_o),
        .rxAcceptNewData_i(rxAcceptNewData_i),
        .rxData_o(rxData_o),
        .rxDataValid_o(rxDataValid_o),
        .rxIsLastByte_o(rxIsLastByte_o),
        .keepPacket_o(keepPacket_o),
        .lineP_i(lineP_i),
        .lineN_i(lineN_i),
        .lineP_o(lineP_o),
        .lineN_o(lineN_o),
        .lineOe_o(lineOe_o)
    );

    assign rxStateLabel = UUT.rxPath.state;

    initial begin
        clk12_i = 1'b0;
        forever #20 clk12_i = ~clk12_i;    // 40 ns period
    end

    // Line capture at mid cycle while tx owns the line
    always @(negedge clk12_i) begin
        if (recordLine && lineOe_o) begin
            lineRec.push_back({lineP_o, lineN_o});
        end
    end

    // ========================================
    // Checking and reference model
    // ========================================

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at %0d ns: %s never came", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "Wait for %s timed out", what);
    endtask

    // Byte idx of the packet with the PID at index 0
    function automatic byteT txByte(input int row, input int idx);
        byteT value;
        if (idx == 0) begin
            value = byteT'(rowPid[row]);
        end else begin
            value = payload[row][idx - 1];
        end
        return value;
    endfunction

    // Reflected CRC16 of the payload in line order with bit 0 sent first
    function automatic logic [15:0] expectedCrc(input int row);
        logic [15:0] revPoly;
        logic [15:0] crcReg;
        byteT cur;
        int i;
        int b;
        for (b = 0; b < 16; b++) begin
            revPoly[b] = crc16Poly[15 - b];     // Bit reversed polynomial
        end
        crcReg = 16'hFFFF;
        for (i = 0; i < rowLen[row]; i++) begin
            cur = payload[row][i];
            for (b = 0; b < 8; b++) begin
                if (crcReg[0] ^ cur[b]) begin
                    crcReg = (crcReg >> 1) ^ revPoly;
                end else begin
                    crcReg = crcReg >> 1;
                end
            end
        end
        return ~crcReg;
    endfunction

    // Zeros inserted after each run of six ones from the PID to the last CRC bit
    function automatic int countStuffedZeros(input int row);
        logic [15:0] crcSent;
        byteT cur;
        logic bitV;
        int ones;
        int stuffed;
        int nBits;
        int i;
        crcSent = expectedCrc(row);
        ones = 0;
        stuffed = 0;
        nBits = 8 * (rowLen[row] + 1);
        for (i = 0; i < nBits + 16; i++) begin
            if (i < nBits) begin
                cur = txByte(row, i / 8);
                bitV = cur[i % 8];
            end else begin
                bitV = crcSent[i - nBits];         // Bit 0 of the reflected CRC leaves first
            end
            ones = bitV ? ones + 1 : 0;
            if (ones == stuffRunLength) begin
                stuffed++;
                ones = 0;
            end
        end
        return stuffed;
    endfunction

    task automatic addRow(input int pid, input int len, input int allOnes,
                          input int fault, input int arg, input int keep);
        int i;
        rowPid[rowCount] = pid;
        rowLen[rowCount] = len;
        rowFault[rowCount] = fault;
        rowArg[rowCount] = arg;
        rowKeep[rowCount] = keep;
        for (i = 0; i < len; i++) begin
            payload[rowCount][i] = (allOnes != 0) ? 8'hFF : byteT'($random(seed));
        end
        rowCount++;
    endtask

    task automatic checkResetState();
        @(negedge clk12_i);
        checkValue("txAcceptNewData_o", txAcceptNewData_o, 0);
        checkValue("txDoneSending_o", txDoneSending_o, 0);
        checkValue("lineOe_o", lineOe_o, 0);
        checkValue("rxDataValid_o", rxDataValid_o, 0);
        checkValue("rxIsLastByte_o", rxIsLastByte_o, 0);
        checkValue("keepPacket_o", keepPacket_o, 0);
        checkValue("lineP_o", lineP_o, 1);     // Idle J
        checkValue("lineN_o", lineN_o, 0);
        checkValue("rxPath state", rxStateLabel, RxHunt);
        @(posedge clk12_i);
        #2;
    endtask

    // ========================================
    // Transmit side
    // ========================================

    task automatic sendPacket(input int row);
        int cycles;
        int sent;
        int nSend;
        logic handshake;
        // Underrun rows stop after the PID and arg payload bytes
        nSend = (rowFault[row] == FaultUnder) ? rowArg[row] + 1 : rowLen[row] + 1;
        isSendingPhase_i = 1'b1;
        lineRec.delete();
        recordLine = 1'b1;
        txReqSendPacket_i = 1'b1;
        @(negedge clk12_i);
        checkValue("lineOe_o", lineOe_o, 0);
        @(posedge clk12_i);
        #2;
        txReqSendPacket_i = 1'b0;
        sent = 0;
        txData_i = txByte(row, 0);
        txDataValid_i = 1'b1;
        txIsLastByte_i = (rowFault[row] != FaultUnder) && (rowLen[row] == 0);
        for (cycles = 0; cycles < TimeoutCycles; cycles++) begin
            @(negedge clk12_i);
            if (cycles == 0) begin
                checkValue("lineOe_o", lineOe_o, 1);   // One cycle after the request
            end
            if (txDoneSending_o) begin
                checkValue("lineOe_o", lineOe_o, 0);   // Line released before done
                break;
            end
            handshake = txDataValid_i && txAcceptNewData_o;
            @(posedge clk12_i);
            #2;
            if (handshake) begin
                sent++;
                if (sent < nSend) begin
                    txData_i = txByte(row, sent);
                    txIsLastByte_i = (rowFault[row] != FaultUnder) && (sent == rowLen[row]);
                end else begin
                    txDataValid_i = 1'b0;              // Nothing more or withheld
                    txIsLastByte_i = 1'b0;
                end
            end
        end
        if (cycles == TimeoutCycles) begin
            reportTimeout("txDoneSending_o");
        end
        recordLine = 1'b0;
        txDataValid_i = 1'b0;
        if (rowFault[row] != FaultUnder) begin
            checkValue("tx bytes taken", sent, nSend);
            // Sync, bytes, CRC, EOP and stuffed zeros
            checkValue("lineOe_o cycles", lineRec.size(),
                       8 + 8 * (rowLen[row] + 1) + 16 + eopSe0Cycles + 1
                       + countStuffedZeros(row));
        end
        @(posedge clk12_i);
        #2;
        isSendingPhase_i = 1'b0;   // Engines go over to rx
    endtask

    // ========================================
    // Receive side
    // ========================================

    task automatic receivePacket(input int row);
        int cycles;
        int replayIdx;
        int got;
        int stallCnt;
        int stallLen;
        logic [1:0] level;
        logic lastSeen;
        logic checkData;
        stallLen = (rowFault[row] == FaultStall) ? rowArg[row] : 0;
        checkData = (rowKeep[row] == 1);   // Faulty packets lose or garble bytes
        replayIdx = 0;
        got = 0;
        stallCnt = 0;
        lastSeen = 1'b0;
        for (cycles = 0; cycles < TimeoutCycles; cycles++) begin
            if (replayIdx < lineRec.size()) begin
                level = lineRec[replayIdx];
                if ((rowFault[row] == FaultFlip) && (replayIdx == rowArg[row])) begin
                    level = ~level;     // J and K swap
                end
                replayIdx++;
            end else begin
                level = 2'b10;          // J
            end
            lineP_i = level[1];
            lineN_i = level[0];
            rxAcceptNewData_i = (stallCnt >= stallLen);
            @(negedge clk12_i);
            if (rxDataValid_o || (stallCnt > 0)) begin
                stallCnt++;             // Stall starts at the first byte offered
            end
            if (rxDataValid_o && rxAcceptNewData_i) begin
                if (checkData) begin
                    checkValue("rxData_o", rxData_o, txByte(row, got));
                    checkValue("rxIsLastByte_o", rxIsLastByte_o, got == rowLen[row]);
                end
                if (rxIsLastByte_o) begin
                    checkValue("keepPacket_o", keepPacket_o, rowKeep[row]);
                    lastSeen = 1'b1;
                end
                got++;
            end
            @(posedge clk12_i);
            #2;
            if (lastSeen && (replayIdx >= lineRec.size())) begin
                break;
            end
        end
        if (cycles == TimeoutCycles) begin
            reportTimeout("rxIsLastByte_o");
        end
        lineP_i = 1'b1;
        lineN_i = 1'b0;
        rxAcceptNewData_i = 1'b1;
        @(negedge clk12_i);
        checkValue("rxDataValid_o", rxDataValid_o, 0);    // Slot empty after the last byte
        checkValue("rxPath state", rxStateLabel, RxHunt); // Back to hunting after the EOP
        @(posedge clk12_i);
        #2;
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        seed = 32'h5c7c1321;
        rowCount = 0;
        reset_i = 1'b1;
        isSendingPhase_i = 1'b0;
        txReqSendPacket_i = 1'b0;
        txDataValid_i = 1'b0;
        txIsLastByte_i = 1'b0;
        txData_i = '0;
        rxAcceptNewData_i = 1'b1;
        lineP_i = 1'b1;
        lineN_i = 1'b0;
        recordLine = 1'b0;

        //     PID    len ones fault       arg keep
        addRow(8'hC3, 8,  0,   FaultNone,  0,  1);
        addRow(8'h4B, 1,  0,   FaultNone,  0,  1);
        addRow(8'hC3, 4,  1,   FaultNone,  0,  1);   // Stuffing inside payload
        addRow(8'h4B, 12, 1,   FaultNone,  0,  1);
        addRow(8'hC3, 16, 0,   FaultFlip,  30, 0);   // Sample 30 lies in the payload
        addRow(8'h4B, 8,  0,   FaultUnder, 3,  0);
        addRow(8'hC3, 16, 0,   FaultStall, 40, 0);   // Well over two byte times
        addRow(8'h4B, 16, 0,   FaultStall, 4,  1);   // Short legal stall
        addRow(8'hC3, 64, 0,   FaultNone,  0,  1);   // Full size packet

        repeat (10) @(posedge clk12_i);
        #2;
        reset_i = 1'b0;
        checkResetState();

        for (int row = 0; row < rowCount; row++) begin
            sendPacket(row);
            receivePacket(row);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
